// File: arbiter/logger_arbiter.sv
// logger arbiter: timestamp requests, channel choice, seven-word sample output and counter
`timescale 1ns/1ps
`default_nettype none

module logger_arbiter
    import logger_pkg::*;
(
    input  logic                    xclk,
    input  logic                    config_rst,
    input  logic                    i_log_off,
    input  logic                    i_ts_stb,
    input  logic [7:0]              i_ts_data,
    logger_chan_if.arbiter          chn_pps,
    logger_chan_if.arbiter          chn_msg,
    output logic                    o_ts_snap,
    output logic [15:0]             o_data,
    output logic                    o_data_stb,
    output logic [SAMPLE_CNT_W-1:0] o_sample_count
);

    logic [NUM_CHN-1:0] ts_rq_in;
    logic [NUM_CHN-1:0] rq_long;                     // request held until granted
    logic [NUM_CHN-1:0] grant;
    logic [NUM_CHN-1:0] granted;                     // timestamp stored, sample pending
    logic [NUM_CHN-1:0] rdy;
    logic [NUM_CHN-1:0] start_ok;
    logic [CHN_W-1:0]   pick;
    logic [CHN_W-1:0]   sel;                         // channel being logged
    logic [2:0]         wcnt;                        // word in sample
    logic               busy;
    logic               data_ph;
    logic               last;
    logic               clr;
    logic [15:0]        ts_word;
    logic [15:0]        chn_data;

    assign clr      = config_rst || i_log_off;
    assign ts_rq_in = {chn_msg.ts_rq, chn_pps.ts_rq};
    assign rdy      = {chn_msg.rdy, chn_pps.rdy};
    assign start_ok = granted & rdy;
    assign chn_data = sel[0] ? chn_msg.rdata : chn_pps.rdata;
    assign data_ph  = busy && (wcnt >= 3'(SAMPLE_WORDS - SAMPLE_DATA_WORDS));

    assign chn_pps.nxt = data_ph && !sel[0];         // advance after each data word
    assign chn_msg.nxt = data_ph && sel[0];

    always_comb begin
        pick = '0;
        for (int i = NUM_CHN - 1; i >= 0; i--) begin
            if (start_ok[i]) begin
                pick = CHN_W'(i);
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (clr) begin
            rq_long <= '0;
            granted <= '0;
            busy    <= 1'b0;
            wcnt    <= 3'd0;
            sel     <= '0;
        end else begin
            rq_long <= (rq_long & ~grant) | ts_rq_in;
            granted <= granted | grant;
            if (!busy && |start_ok) begin
                busy          <= 1'b1;
                wcnt          <= 3'd0;
                sel           <= pick;
                granted[pick] <= 1'b0;               // timestamp consumed by this sample
            end else if (busy) begin
                wcnt <= wcnt + 3'd1;
                if (wcnt == 3'(SAMPLE_WORDS - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // registered output mux, one cycle behind the word counter
    always_ff @(posedge xclk) begin
        case (wcnt)
            3'd0:       o_data <= 16'(sel);
            3'd1, 3'd2: o_data <= ts_word;
            default:    o_data <= rdy[sel] ? chn_data : 16'h0;
        endcase
    end

    always_ff @(posedge xclk) begin
        if (clr) begin
            o_data_stb     <= 1'b0;
            last           <= 1'b0;
            o_sample_count <= '0;
        end else begin
            o_data_stb <= busy;
            last       <= busy && (wcnt == 3'(SAMPLE_WORDS - 1));
            if (last) begin
                o_sample_count <= o_sample_count + 1'b1;
            end
        end
    end

    ts_store u_ts_store (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_log_off  (i_log_off),
        .i_ts_rq    (rq_long),
        .i_ts_stb   (i_ts_stb),
        .i_ts_data  (i_ts_data),
        .i_rd_chn   (sel),
        .i_rd_hi    (wcnt == 3'd2),                  // word 2 - high half
        .o_ts_grant (grant),
        .o_ts_snap  (o_ts_snap),
        .o_rd_word  (ts_word)
    );

endmodule

`default_nettype wire

// File: arbiter/ts_store.sv
// timestamp store: local time snapshot sequencer with one 32-bit slot per channel
`timescale 1ns/1ps
`default_nettype none

module ts_store
    import logger_pkg::*;
(
    input  logic               xclk,
    input  logic               config_rst,
    input  logic               i_log_off,
    input  logic [NUM_CHN-1:0] i_ts_rq,              // held until granted
    input  logic               i_ts_stb,             // one cycle before the bytes
    input  logic [7:0]         i_ts_data,            // lsb first
    input  logic [CHN_W-1:0]   i_rd_chn,
    input  logic               i_rd_hi,
    output logic [NUM_CHN-1:0] o_ts_grant,
    output logic               o_ts_snap,
    output logic [15:0]        o_rd_word
);

    logic [8*TS_BYTES-1:0]       slot [NUM_CHN];
    logic [NUM_CHN-1:0]          rq_m;
    logic [CHN_W-1:0]            pick;
    logic [CHN_W-1:0]            cur;                // channel being served
    logic [$clog2(TS_BYTES)-1:0] bcnt;
    logic                        busy;               // snapshot in flight
    logic                        recv;               // bytes arriving
    logic                        clr;

    assign clr  = config_rst || i_log_off;
    assign rq_m = i_ts_rq & ~o_ts_grant;             // request drops a cycle after grant

    always_comb begin
        pick = '0;
        for (int i = NUM_CHN - 1; i >= 0; i--) begin
            if (rq_m[i]) begin
                pick = CHN_W'(i);                    // lowest wins
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (clr) begin
            busy       <= 1'b0;
            recv       <= 1'b0;
            bcnt       <= '0;
            o_ts_snap  <= 1'b0;
            o_ts_grant <= '0;
        end else begin
            o_ts_snap  <= 1'b0;
            o_ts_grant <= '0;
            if (!busy) begin
                if (|rq_m) begin
                    busy      <= 1'b1;
                    cur       <= pick;
                    o_ts_snap <= 1'b1;
                end
            end else if (!recv) begin
                if (i_ts_stb) begin
                    recv <= 1'b1;
                    bcnt <= '0;
                end
            end else begin
                bcnt <= bcnt + 1'b1;
                if (bcnt == TS_BYTES - 1) begin
                    busy            <= 1'b0;
                    recv            <= 1'b0;
                    o_ts_grant[cur] <= 1'b1;         // slot complete
                end
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (recv) begin
            slot[cur][8*bcnt +: 8] <= i_ts_data;
        end
    end

    assign o_rd_word = i_rd_hi ? slot[i_rd_chn][8*TS_BYTES-1 -: 16] : slot[i_rd_chn][15:0];

endmodule

`default_nettype wire

// File: common/logger_chan_if.sv
// logger channel link: timestamp request, data ready, next-word strobe and read data
`timescale 1ns/1ps
`default_nettype none

interface logger_chan_if;

    logic        ts_rq;                              // single cycle, asks for a timestamp
    logic        rdy;                                // level, channel has a sample to log
    logic        nxt;                                // single cycle, word taken
    logic [15:0] rdata;                              // current data word

    modport source (
        output ts_rq, rdy, rdata,
        input  nxt
    );

    modport arbiter (
        input  ts_rq, rdy, rdata,
        output nxt
    );

endinterface

`default_nettype wire

// File: common/logger_pkg.sv
// logger package: register map, config field positions, sample layout and the command word
`default_nettype none

package logger_pkg;

    localparam int GPIO_N       = 10;                // external inputs
    localparam int CTRL_ADDR_W  = 7;                 // control address register

    localparam logic [CTRL_ADDR_W-1:0] LOGGER_CONFIG   = 7'd3;
    localparam logic [1:0]             LOGGER_PAGE_MSG = 2'd2;   // 'h40..'h5f, top two address bits

    localparam int MSG_WORDS    = 4;                 // software message words

    localparam int CONF_GPS     = 7;                 // enable for gps field 6:3
    localparam int CONF_MSG     = 13;                // enable for msg field 12:8
    localparam int CONF_EN      = 20;                // enable for log-off bit 19

    localparam logic [7:0] DENOISE_COUNT = 8'd255;   // 256 stable cycles to accept a pps edge

    localparam int NUM_CHN      = 2;                 // 0 - pps, 1 - message
    localparam int CHN_W        = $clog2(NUM_CHN);

    localparam int SAMPLE_WORDS      = 7;            // chn, ts lo, ts hi, 4 data
    localparam int SAMPLE_DATA_WORDS = 4;
    localparam int TS_BYTES          = 4;            // local timestamp, lsb first
    localparam int SAMPLE_CNT_W      = 24;

    // one command data word, read either as a message word or as config fields
    typedef union packed {
        logic [31:0] raw;                            // message word in 15:0
        struct packed {
            logic [10:0] rsv_hi;                     // 31:21
            logic        en_we;                      // 20
            logic        log_off;                    // 19
            logic [4:0]  rsv_mid;                    // 18:14
            logic        msg_we;                     // 13
            logic        msg_inv;                    // 12
            logic [3:0]  msg_sel;                    // 11:8, 15 - off
            logic        gps_we;                     // 7
            logic        gps_rsv;                    // 6, was nmea mode
            logic        gps_inv;                    // 5
            logic [1:0]  gps_sel;                    // 4:3, 0/3 - off
            logic [2:0]  rsv_lo;                     // 2:0, imu config in the full logger
        } cfg;
    } cmd_word_u;

endpackage

`default_nettype wire

// File: source/event_logger.sv
// event logger top: command decoder, pps and message channels, arbiter with timestamp store
`timescale 1ns/1ps
`default_nettype none

module event_logger
    import logger_pkg::*;
(
    input  logic                    xclk,
    input  logic                    config_rst,      // sync, active high
    input  logic                    i_cmd_stb,
    input  logic                    i_cmd_a,
    input  logic [31:0]             i_cmd_data,
    input  logic [GPIO_N-1:0]       i_ext_di,
    input  logic                    i_ts_stb,
    input  logic [7:0]              i_ts_data,
    output logic                    o_ts_snap,       // take local time snapshot
    output logic [15:0]             o_data,
    output logic                    o_data_stb,
    output logic [SAMPLE_CNT_W-1:0] o_sample_count
);

    logic [1:0]  gps_sel;
    logic        gps_inv;
    logic [3:0]  msg_sel;
    logic        msg_inv;
    logic        log_off;
    logic        msg_we;
    logic [1:0]  msg_idx;
    logic [15:0] msg_word;

    logger_chan_if chn_pps ();                       // channel 0
    logger_chan_if chn_msg ();                       // channel 1

    logger_regs u_regs (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_cmd_stb  (i_cmd_stb),
        .i_cmd_a    (i_cmd_a),
        .i_cmd_data (i_cmd_data),
        .o_gps_sel  (gps_sel),
        .o_gps_inv  (gps_inv),
        .o_msg_sel  (msg_sel),
        .o_msg_inv  (msg_inv),
        .o_log_off  (log_off),
        .o_msg_we   (msg_we),
        .o_msg_idx  (msg_idx),
        .o_msg_word (msg_word)
    );

    pps_filter u_pps (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_ext_di   (i_ext_di),
        .i_gps_sel  (gps_sel),
        .i_gps_inv  (gps_inv),
        .i_log_off  (log_off),
        .chn        (chn_pps.source)
    );

    msg_channel u_msg (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_ext_di   (i_ext_di),
        .i_msg_sel  (msg_sel),
        .i_msg_inv  (msg_inv),
        .i_log_off  (log_off),
        .i_msg_we   (msg_we),
        .i_msg_idx  (msg_idx),
        .i_msg_word (msg_word),
        .chn        (chn_msg.source)
    );

    logger_arbiter u_arbiter (
        .xclk           (xclk),
        .config_rst     (config_rst),
        .i_log_off      (log_off),
        .i_ts_stb       (i_ts_stb),
        .i_ts_data      (i_ts_data),
        .chn_pps        (chn_pps.arbiter),
        .chn_msg        (chn_msg.arbiter),
        .o_ts_snap      (o_ts_snap),
        .o_data         (o_data),
        .o_data_stb     (o_data_stb),
        .o_sample_count (o_sample_count)
    );

endmodule

`default_nettype wire

// File: source/logger_regs.sv
// logger command decoder: control address, config fields and message word writes
`timescale 1ns/1ps
`default_nettype none

module logger_regs
    import logger_pkg::*;
(
    input  logic        xclk,
    input  logic        config_rst,                  // sync, active high
    input  logic        i_cmd_stb,                   // one write per cycle
    input  logic        i_cmd_a,                     // 1 - address, 0 - data
    input  logic [31:0] i_cmd_data,
    output logic [1:0]  o_gps_sel,                   // 1 - gpio 3, 2 - gpio 5, else off
    output logic        o_gps_inv,
    output logic [3:0]  o_msg_sel,                   // gpio index, 15 - off
    output logic        o_msg_inv,
    output logic        o_log_off,
    output logic        o_msg_we,
    output logic [1:0]  o_msg_idx,
    output logic [15:0] o_msg_word
);

    cmd_word_u              cmd;
    logic [CTRL_ADDR_W-1:0] ctrl_addr;
    logic                   data_we;
    logic                   cfg_we;
    logic                   page_we;

    assign cmd     = cmd_word_u'(i_cmd_data);
    assign data_we = i_cmd_stb && !i_cmd_a;
    assign cfg_we  = data_we && (ctrl_addr == LOGGER_CONFIG);
    assign page_we = data_we && (ctrl_addr[CTRL_ADDR_W-1 -: 2] == LOGGER_PAGE_MSG);

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            ctrl_addr <= '0;
        end else if (i_cmd_stb && i_cmd_a) begin
            ctrl_addr <= i_cmd_data[CTRL_ADDR_W-1:0];
        end else if (page_we && (ctrl_addr[4:0] != 5'h1f)) begin
            ctrl_addr[4:0] <= ctrl_addr[4:0] + 5'd1; // no roll over past page end
        end
    end

    // each field is written only when its enable bit is set in the same word
    always_ff @(posedge xclk) begin
        if (config_rst) begin
            o_gps_sel <= 2'd0;                       // off
            o_gps_inv <= 1'b0;
            o_msg_sel <= 4'hf;                       // off
            o_msg_inv <= 1'b0;
            o_log_off <= 1'b0;
        end else if (cfg_we) begin
            if (cmd.raw[CONF_GPS]) begin
                o_gps_sel <= cmd.cfg.gps_sel;
                o_gps_inv <= cmd.cfg.gps_inv;
            end
            if (cmd.raw[CONF_MSG]) begin
                o_msg_sel <= cmd.cfg.msg_sel;
                o_msg_inv <= cmd.cfg.msg_inv;
            end
            if (cmd.raw[CONF_EN]) begin
                o_log_off <= cmd.cfg.log_off;
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            o_msg_we <= 1'b0;
        end else begin
            o_msg_we <= page_we;
        end
    end

    always_ff @(posedge xclk) begin
        if (page_we) begin
            o_msg_idx  <= ctrl_addr[1:0];            // word within message
            o_msg_word <= cmd.raw[15:0];
        end
    end

endmodule

`default_nettype wire

// File: source/msg_channel.sv
// message channel: trigger select, edge detect and the software-written message buffer
`timescale 1ns/1ps
`default_nettype none

module msg_channel
    import logger_pkg::*;
(
    input  logic              xclk,
    input  logic              config_rst,
    input  logic [GPIO_N-1:0] i_ext_di,
    input  logic [3:0]        i_msg_sel,             // 15 - off
    input  logic              i_msg_inv,
    input  logic              i_log_off,
    input  logic              i_msg_we,
    input  logic [1:0]        i_msg_idx,
    input  logic [15:0]       i_msg_word,
    logger_chan_if.source     chn
);

    logic [15:0]                  ext16;             // inputs padded to the select range
    logic                         trig;
    logic                         trig_d;
    logic [15:0]                  msg_mem [MSG_WORDS];
    logic [$clog2(MSG_WORDS)-1:0] rd_ptr;
    logic                         clr;

    assign clr   = config_rst || i_log_off;
    assign ext16 = 16'(i_ext_di);
    assign trig  = (i_msg_sel != 4'hf) && (ext16[i_msg_sel] ^ i_msg_inv);

    always_ff @(posedge xclk) begin
        if (i_msg_we) begin
            msg_mem[i_msg_idx] <= i_msg_word;
        end
    end

    // leading edge takes the time, trailing edge releases the message
    always_ff @(posedge xclk) begin
        if (clr) begin
            trig_d    <= 1'b0;
            chn.ts_rq <= 1'b0;
            chn.rdy   <= 1'b0;
            rd_ptr    <= '0;
        end else begin
            trig_d    <= trig;
            chn.ts_rq <= trig && !trig_d;
            if (!trig && trig_d) begin
                chn.rdy <= 1'b1;
                rd_ptr  <= '0;                       // start from word 0
            end else if (chn.nxt) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (rd_ptr == MSG_WORDS - 1) begin
                    chn.rdy <= 1'b0;                 // all words taken
                end
            end
        end
    end

    assign chn.rdata = msg_mem[rd_ptr];

endmodule

`default_nettype wire

// File: source/pps_filter.sv
// gps pps channel: input select, synchronizer, 256-cycle de-noise and pulse counter
`timescale 1ns/1ps
`default_nettype none

module pps_filter
    import logger_pkg::*;
(
    input  logic              xclk,
    input  logic              config_rst,
    input  logic [GPIO_N-1:0] i_ext_di,
    input  logic [1:0]        i_gps_sel,
    input  logic              i_gps_inv,
    input  logic              i_log_off,
    logger_chan_if.source     chn
);

    logic        pulse;                              // selected, inverted input
    logic [2:0]  sync;
    logic [7:0]  dn_cnt;                             // cycles left before accepting a change
    logic        state;                              // filtered pps level
    logic        state_d;
    logic        rise;
    logic [15:0] pulse_cnt;
    logic        clr;

    assign clr = config_rst || i_log_off;

    always_comb begin
        case (i_gps_sel)
            2'd1:    pulse = i_ext_di[3] ^ i_gps_inv;
            2'd2:    pulse = i_ext_di[5] ^ i_gps_inv;
            default: pulse = 1'b0;                   // disabled, no inversion either
        endcase
    end

    always_ff @(posedge xclk) begin
        if (clr) begin
            sync    <= 3'b0;
            dn_cnt  <= DENOISE_COUNT;
            state   <= 1'b0;
            state_d <= 1'b0;
            rise    <= 1'b0;
        end else begin
            sync <= {sync[1:0], pulse};
            if (sync[2] == state) begin
                dn_cnt <= DENOISE_COUNT;             // glitch restarts the wait
            end else begin
                dn_cnt <= dn_cnt - 8'd1;
            end
            if (dn_cnt == 8'd0) begin
                state <= sync[2];
            end
            state_d <= state;
            rise    <= state && !state_d;
        end
    end

    always_ff @(posedge xclk) begin
        if (clr) begin
            chn.ts_rq <= 1'b0;
            chn.rdy   <= 1'b0;
        end else begin
            chn.ts_rq <= rise;                       // two cycles after filtered rise
            if (rise) begin
                chn.rdy <= 1'b1;
            end else if (chn.nxt) begin
                chn.rdy <= 1'b0;                     // only word 0 carries the count
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            pulse_cnt <= 16'd0;
        end else if (rise) begin
            pulse_cnt <= pulse_cnt + 16'd1;
        end
    end

    assign chn.rdata = pulse_cnt;

endmodule

`default_nettype wire

// File: tb/tb_event_logger.sv
// event logger testbench: stimulus table, timestamp responder, sample monitor and checks
`timescale 1ns/1ps
`default_nettype none

module tb_event_logger
    import logger_pkg::*;
();

    localparam logic [2:0] K_WAIT = 3'd0;            // idle cycles only
    localparam logic [2:0] K_ADDR = 3'd1;            // command address write
    localparam logic [2:0] K_DATA = 3'd2;            // command data write
    localparam logic [2:0] K_GPIO = 3'd3;            // set gpio idle levels
    localparam logic [2:0] K_PPS  = 3'd4;            // flip gpio bits for len cycles, pps input
    localparam logic [2:0] K_TRIG = 3'd5;            // same, message trigger
    localparam int MAX_STEPS = 32;
    localparam int MAX_SMP   = 16;
    localparam int MAX_GOT   = 32;

    logic                    xclk;
    logic                    config_rst;
    logic                    i_cmd_stb;
    logic                    i_cmd_a;
    logic [31:0]             i_cmd_data;
    logic [GPIO_N-1:0]       i_ext_di;
    logic                    i_ts_stb;
    logic [7:0]              i_ts_data;
    logic                    o_ts_snap;
    logic [15:0]             o_data;
    logic                    o_data_stb;
    logic [SAMPLE_CNT_W-1:0] o_sample_count;

    logic [2:0]              t_kind  [MAX_STEPS];
    logic [31:0]             t_arg   [MAX_STEPS];    // command word or gpio mask
    int                      t_len   [MAX_STEPS];
    int                      t_gap   [MAX_STEPS];    // settle cycles before the checks
    int                      t_snaps [MAX_STEPS];
    int                      t_beh   [MAX_STEPS];
    int                      t_first [MAX_STEPS];    // first expected sample of the step
    int                      t_nsmp  [MAX_STEPS];
    logic [SAMPLE_CNT_W-1:0] t_cnt   [MAX_STEPS];
    logic [15:0]             e_chn   [MAX_SMP];
    int                      e_tsi   [MAX_SMP];      // timestamp index, in snapshot order
    logic [15:0]             e_dat   [4*MAX_SMP];
    logic [31:0]             ts_tab  [MAX_SMP];
    logic [15:0]             got_w   [7*MAX_GOT];
    logic [31:0]             lfsr;
    logic [31:0]             ts_cur;
    int n_steps  = 0;
    int n_exp    = 0;
    int n_got    = 0;
    int wpos     = 0;                                // word position in the sample
    int snap_cnt = 0;
    int resp_idx = 0;
    int errors   = 0;
    int checks   = 0;
    int cycles   = 0;

    event_logger u_dut (
        .xclk           (xclk),
        .config_rst     (config_rst),
        .i_cmd_stb      (i_cmd_stb),
        .i_cmd_a        (i_cmd_a),
        .i_cmd_data     (i_cmd_data),
        .i_ext_di       (i_ext_di),
        .i_ts_stb       (i_ts_stb),
        .i_ts_data      (i_ts_data),
        .o_ts_snap      (o_ts_snap),
        .o_data         (o_data),
        .o_data_stb     (o_data_stb),
        .o_sample_count (o_sample_count)
    );

    initial begin
        xclk = 1'b0;
        forever #50 xclk = ~xclk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    task automatic add_step(input logic [2:0] kind, input logic [31:0] arg, input int len,
                            input int gap, input int snaps, input int cnt, input int beh);
        t_kind[n_steps]  = kind;
        t_arg[n_steps]   = arg;
        t_len[n_steps]   = len;
        t_gap[n_steps]   = gap;
        t_snaps[n_steps] = snaps;
        t_cnt[n_steps]   = SAMPLE_CNT_W'(cnt);
        t_beh[n_steps]   = beh;
        t_first[n_steps] = n_exp;
        t_nsmp[n_steps]  = 0;
        n_steps = n_steps + 1;
    endtask

    // attaches one expected sample to the last step
    task automatic expect_sample(input int chn, input int tsi, input logic [15:0] d0,
                                 input logic [15:0] d1, input logic [15:0] d2,
                                 input logic [15:0] d3);
        e_chn[n_exp]       = 16'(chn);
        e_tsi[n_exp]       = tsi;
        e_dat[4*n_exp]     = d0;
        e_dat[4*n_exp + 1] = d1;
        e_dat[4*n_exp + 2] = d2;
        e_dat[4*n_exp + 3] = d3;
        n_exp = n_exp + 1;
        t_nsmp[n_steps-1] = t_nsmp[n_steps-1] + 1;
    endtask

    task automatic build_table();
        add_step(K_WAIT, 32'h0, 0, 100, 0, 0, 1);              // quiet after reset
        add_step(K_ADDR, 32'd3, 0, 2, 0, 0, 2);                // config register
        add_step(K_DATA, 32'h0000_0088, 0, 2, 0, 0, 2);        // gps_we, sel 1
        add_step(K_PPS, 32'h008, 400, 600, 1, 1, 2);
        expect_sample(0, 0, 16'd1, 16'd0, 16'd0, 16'd0);
        add_step(K_GPIO, 32'h0a0, 0, 10, 0, 1, 2);             // gpio 5 and 7 idle high
        add_step(K_DATA, 32'h0000_00b0, 0, 10, 0, 1, 2);       // gps_we, inv, sel 2
        add_step(K_PPS, 32'h020, 400, 600, 1, 2, 2);
        expect_sample(0, 1, 16'd2, 16'd0, 16'd0, 16'd0);
        add_step(K_PPS, 32'h020, 100, 600, 0, 2, 3);           // too short, filtered out
        add_step(K_ADDR, 32'h40, 0, 2, 0, 2, 4);               // message page, word 0
        add_step(K_DATA, 32'hffff_7e01, 0, 2, 0, 2, 4);
        add_step(K_DATA, 32'hffff_81c3, 0, 2, 0, 2, 4);
        add_step(K_DATA, 32'hffff_0ff0, 0, 2, 0, 2, 4);
        add_step(K_DATA, 32'hffff_a55a, 0, 2, 0, 2, 4);
        add_step(K_ADDR, 32'd3, 0, 2, 0, 2, 4);
        add_step(K_DATA, 32'h0000_3700, 0, 10, 0, 2, 4);       // msg_we, inv, sel 7
        add_step(K_TRIG, 32'h080, 20, 100, 1, 3, 4);
        expect_sample(1, 2, 16'h7e01, 16'h81c3, 16'h0ff0, 16'ha55a);
        add_step(K_PPS, 32'h0a0, 400, 600, 2, 5, 5);           // both together, msg snaps first
        expect_sample(0, 4, 16'd3, 16'd0, 16'd0, 16'd0);
        expect_sample(1, 3, 16'h7e01, 16'h81c3, 16'h0ff0, 16'ha55a);
        add_step(K_DATA, 32'h0018_0000, 0, 10, 0, 0, 6);       // log off
        add_step(K_PPS, 32'h0a0, 400, 600, 0, 0, 6);
        add_step(K_DATA, 32'h0010_0000, 0, 10, 0, 0, 6);       // log on again
        add_step(K_TRIG, 32'h080, 20, 100, 1, 1, 6);
        expect_sample(1, 5, 16'h7e01, 16'h81c3, 16'h0ff0, 16'ha55a);
    endtask

    task automatic apply_step(input int s);
        case (t_kind[s])
            K_ADDR, K_DATA: begin
                i_cmd_stb  <= 1'b1;
                i_cmd_a    <= (t_kind[s] == K_ADDR);
                i_cmd_data <= t_arg[s];
                @(posedge xclk);
                i_cmd_stb  <= 1'b0;
            end
            K_GPIO: i_ext_di <= t_arg[s][GPIO_N-1:0];
            K_PPS, K_TRIG: begin
                i_ext_di <= i_ext_di ^ t_arg[s][GPIO_N-1:0];   // active level
                repeat (t_len[s]) @(posedge xclk);
                i_ext_di <= i_ext_di ^ t_arg[s][GPIO_N-1:0];   // back to idle
            end
            default: ;
        endcase
        repeat (t_gap[s]) @(posedge xclk);
    endtask

    task automatic check_step(input int s, input int snap0, input int got0);
        int          err0;
        int          ns;
        int          ng;
        int          gi;
        int          ei;
        logic [15:0] exp_w;
        err0 = errors;
        ns   = snap_cnt - snap0;
        ng   = n_got - got0;
        checks = checks + 3;
        if (ns != t_snaps[s]) begin
            $display("step %0d: expected %0d timestamp snapshots, saw %0d", s, t_snaps[s], ns);
            errors++;
        end
        if (wpos != 0) begin
            $display("step %0d: a sample is still being sent at the end of the step", s);
            errors++;
        end
        if (ng != t_nsmp[s]) begin
            $display("step %0d: %s sample, expected %0d samples and got %0d", s,
                     (ng < t_nsmp[s]) ? "missing" : "extra", t_nsmp[s], ng);
            errors++;
        end else begin
            for (int j = 0; j < ng; j++) begin
                gi = got0 + j;
                ei = t_first[s] + j;
                for (int k = 0; k < SAMPLE_WORDS; k++) begin
                    case (k)
                        0:       exp_w = e_chn[ei];
                        1:       exp_w = ts_tab[e_tsi[ei]][15:0];
                        2:       exp_w = ts_tab[e_tsi[ei]][31:16];
                        default: exp_w = e_dat[4*ei + k - 3];
                    endcase
                    checks++;
                    if (got_w[7*gi + k] !== exp_w) begin
                        $display("ERR step %0d sample %0d o_data word %0d: got %h expected %h",
                                 s, j, k, got_w[7*gi + k], exp_w);
                        errors++;
                    end
                end
            end
        end
        if (o_sample_count !== t_cnt[s]) begin
            $display("ERR step %0d o_sample_count: got %h expected %h", s, o_sample_count,
                     t_cnt[s]);
            errors++;
        end
        if (errors == err0) begin
            $display("step %0d behavior %0d: ok, %0d samples", s, t_beh[s], ng);
        end else begin
            $display("step %0d behavior %0d: %0d errors", s, t_beh[s], errors - err0);
        end
    endtask

    // answers each snapshot after a varying wait, then four bytes lsb first
    always begin
        @(negedge xclk);
        if (o_ts_snap === 1'b1) begin
            snap_cnt = snap_cnt + 1;
            ts_cur   = ts_tab[resp_idx % MAX_SMP];
            repeat (2 + resp_idx % 4) @(posedge xclk);
            resp_idx = resp_idx + 1;
            i_ts_stb <= 1'b1;
            for (int b = 0; b < TS_BYTES; b++) begin
                @(posedge xclk);
                i_ts_stb  <= 1'b0;
                i_ts_data <= ts_cur[8*b +: 8];
            end
            @(posedge xclk);
            i_ts_data <= 8'h00;
        end
    end

    // collects strobed words into samples, a gap inside a sample is an error
    always @(negedge xclk) begin
        if (o_data_stb === 1'b1) begin
            if (n_got < MAX_GOT) begin
                got_w[7*n_got + wpos] = o_data;
            end
            if (wpos == SAMPLE_WORDS - 1) begin
                wpos  = 0;
                n_got = n_got + 1;
            end else begin
                wpos = wpos + 1;
            end
        end else if (wpos != 0) begin
            $display("sample %0d broken off after %0d words", n_got, wpos);
            errors++;
            wpos = 0;
        end
    end

    always @(posedge xclk) begin
        cycles <= cycles + 1;
        if (cycles > n_steps * 2000) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int snap0;
        int got0;
        config_rst = 1'b1;
        i_cmd_stb  = 1'b0;
        i_cmd_a    = 1'b0;
        i_cmd_data = 32'h0;
        i_ext_di   = '0;
        i_ts_stb   = 1'b0;
        i_ts_data  = 8'h00;
        lfsr       = 32'h08c1_3342;
        for (int i = 0; i < MAX_SMP; i++) begin
            for (int b = 0; b < 32; b++) begin
                lfsr         = lfsr_next(lfsr);  // one step per timestamp bit
                ts_tab[i][b] = lfsr[0];
            end
        end
        build_table();
        repeat (2) @(posedge xclk);
        config_rst <= 1'b0;
        for (int s = 0; s < n_steps; s++) begin
            snap0 = snap_cnt;
            got0  = n_got;
            apply_step(s);
            check_step(s, snap0, got0);
        end
        $display("%0d steps, %0d checks, %0d errors", n_steps, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
common/logger_pkg.sv
common/logger_chan_if.sv
source/logger_regs.sv
source/pps_filter.sv
source/msg_channel.sv
arbiter/ts_store.sv
arbiter/logger_arbiter.sv
source/event_logger.sv
tb/tb_event_logger.sv
